// ==== Makefile ====
# Verilator flow for the core testbench; the run step fails when the testbench fails
TOP := mipsCoreTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f mipsCore.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f mipsCore.f

clean:
	rm -rf obj_dir

// ==== hdl/aluExecute.sv ====
// Execute stage that never stalls and wraps add and sub modulo 2^32 without overflow traps
`timescale 1ns/1ps

module aluExecute
  import mipsPkg::*;
(
  input  logic    begintest,
  input  logic    rstN,
  input  logic    decValid,
  input  aluOpT   decAluOp,
  input  wordT    decOpA,
  input  wordT    decOpB,
  input  regAddrT decDest,
  input  logic    decWrite,
  input  logic    decLoad,
  input  logic    decStore,
  input  wordT    decStoreData,
  input  logic    decIllegal,
  output logic    exValid,
  output wordT    exResult,
  output regAddrT exDest,
  output logic    exWrite,
  output logic    exLoad,
  output logic    exStore,
  output wordT    exStoreData,
  output logic    exIllegal
);

  wordT aluOut;

  // ----------------------------------------
  // ALU
  // ----------------------------------------
  always_comb begin
    case (decAluOp)
      aluAdd:  aluOut = decOpA + decOpB;
      aluSub:  aluOut = decOpA - decOpB;
      aluAnd:  aluOut = decOpA & decOpB;
      aluOr:   aluOut = decOpA | decOpB;
      aluXor:  aluOut = decOpA ^ decOpB;
      // Signed compare, result is 1 or 0
      aluSlt:  aluOut = {31'b0, $signed(decOpA) < $signed(decOpB)};
      // Immediate already sits in the upper half
      aluLui:  aluOut = decOpB;
      default: aluOut = '0;
    endcase
  end

  // Control bits follow the valid of the previous stage
  always_ff @(posedge begintest) begin
    if (!rstN) begin
      exValid   <= 1'b0;
      exWrite   <= 1'b0;
      exLoad    <= 1'b0;
      exStore   <= 1'b0;
      exIllegal <= 1'b0;
    end else begin
      exValid   <= decValid;
      exWrite   <= decValid && decWrite;
      exLoad    <= decValid && decLoad;
      exStore   <= decValid && decStore;
      exIllegal <= decValid && decIllegal;
    end
  end

  // Result and payload
  always_ff @(posedge begintest) begin
    exResult    <= aluOut;
    exDest      <= decDest;
    exStoreData <= decStoreData;
  end

endmodule

// ==== hdl/instDecode.sv ====
// Decode stage that stalls instReady on any RAW hazard since the pipeline has no forwarding paths
`timescale 1ns/1ps

module instDecode
  import mipsPkg::*;
(
  input  logic    begintest,
  input  logic    rstN,
  input  logic    instValid,
  input  wordT    instWord,
  output logic    instReady,
  output regAddrT rdAddrA,
  output regAddrT rdAddrB,
  input  wordT    rdDataA,
  input  wordT    rdDataB,
  input  logic    exValid,
  input  logic    exWrite,
  input  regAddrT exDest,
  input  logic    wbEnable,
  input  regAddrT wbAddr,
  output logic    decValid,
  output aluOpT   decAluOp,
  output wordT    decOpA,
  output wordT    decOpB,
  output regAddrT decDest,
  output logic    decWrite,
  output logic    decLoad,
  output logic    decStore,
  output wordT    decStoreData,
  output logic    decIllegal
);

  // Instruction fields
  opcodeT  opcode;
  functT   funct;
  regAddrT rs;
  regAddrT rt;
  regAddrT rd;
  immT     imm;

  // Decoded controls
  aluOpT   aluOp;
  logic    useImm;
  logic    destRt;
  logic    write;
  logic    load;
  logic    store;
  logic    illegal;
  logic    extSign;
  logic    extUpper;
  regAddrT destReg;
  wordT    immExt;

  // Interlock
  logic    useRt;
  logic    rsHit;
  logic    rtHit;
  logic    accept;

  assign opcode = instWord[31:26];
  assign rs     = instWord[25:21];
  assign rt     = instWord[20:16];
  assign rd     = instWord[15:11];
  assign funct  = instWord[5:0];
  assign imm    = instWord[15:0];

  // Operand reads go straight to the register file
  assign rdAddrA = rs;
  assign rdAddrB = rt;

  // ----------------------------------------
  // Control unit
  // ----------------------------------------
  always_comb begin
    aluOp    = aluAdd;
    useImm   = 1'b1;
    destRt   = 1'b1;
    write    = 1'b1;
    load     = 1'b0;
    store    = 1'b0;
    illegal  = 1'b0;
    extSign  = 1'b1;
    extUpper = 1'b0;
    case (opcode)
      opRtype: begin
        useImm = 1'b0;
        destRt = 1'b0;
        case (funct)
          fnAddu:  aluOp = aluAdd;
          fnSubu:  aluOp = aluSub;
          fnAnd:   aluOp = aluAnd;
          fnOr:    aluOp = aluOr;
          fnXor:   aluOp = aluXor;
          fnSlt:   aluOp = aluSlt;
          default: illegal = 1'b1;
        endcase
      end
      opAddiu: aluOp = aluAdd;
      opSlti:  aluOp = aluSlt;
      opAndi: begin
        aluOp   = aluAnd;
        extSign = 1'b0;
      end
      opOri: begin
        aluOp   = aluOr;
        extSign = 1'b0;
      end
      opXori: begin
        aluOp   = aluXor;
        extSign = 1'b0;
      end
      opLui: begin
        aluOp    = aluLui;
        extUpper = 1'b1;
      end
      // Address is base plus signed offset
      opLw: load = 1'b1;
      opSw: begin
        store = 1'b1;
        write = 1'b0;
      end
      default: illegal = 1'b1;
    endcase
    // Illegal instructions touch no state
    if (illegal) begin
      write = 1'b0;
      load  = 1'b0;
      store = 1'b0;
    end
  end

  // rd for R-type, rt otherwise
  assign destReg = destRt ? rt : rd;

  // Sign, zero or upper-half placement of the immediate
  assign immExt = extUpper ? {imm, 16'h0000} :
                  extSign  ? {{16{imm[15]}}, imm} :
                             {16'h0000, imm};

  // ----------------------------------------
  // RAW interlock
  // ----------------------------------------
  // rt is a source only for R-type and sw
  assign useRt = (opcode == opRtype) || (opcode == opSw);

  assign rsHit = (rs != '0) &&
                 ((decValid && decWrite && (decDest == rs)) ||
                  (exValid && exWrite && (exDest == rs)) ||
                  (wbEnable && (wbAddr == rs)));

  assign rtHit = useRt && (rt != '0) &&
                 ((decValid && decWrite && (decDest == rt)) ||
                  (exValid && exWrite && (exDest == rt)) ||
                  (wbEnable && (wbAddr == rt)));

  assign instReady = !(rsHit || rtHit);
  assign accept    = instValid && instReady;

  // Control bits drop to zero on idle cycles
  always_ff @(posedge begintest) begin
    if (!rstN) begin
      decValid   <= 1'b0;
      decWrite   <= 1'b0;
      decLoad    <= 1'b0;
      decStore   <= 1'b0;
      decIllegal <= 1'b0;
    end else begin
      decValid   <= accept;
      // Writes to register 0 are dropped here
      decWrite   <= accept && write && (destReg != '0);
      decLoad    <= accept && load;
      decStore   <= accept && store;
      decIllegal <= accept && illegal;
    end
  end

  // Operand and field payload
  always_ff @(posedge begintest) begin
    if (accept) begin
      decAluOp     <= aluOp;
      decOpA       <= rdDataA;
      decOpB       <= useImm ? immExt : rdDataB;
      decDest      <= destReg;
      decStoreData <= rdDataB;
    end
  end

endmodule

// ==== hdl/memResult.sv ====
// Result stage with word-only data memory and DMEM_WORDS must be a power of two of at least 2
`timescale 1ns/1ps

module memResult
  import mipsPkg::*;
#(
  parameter int DMEM_WORDS = 64
) (
  input  logic    begintest,
  input  logic    rstN,
  input  logic    exValid,
  input  wordT    exResult,
  input  regAddrT exDest,
  input  logic    exWrite,
  input  logic    exLoad,
  input  logic    exStore,
  input  wordT    exStoreData,
  input  logic    exIllegal,
  output logic    wbEnable,
  output regAddrT wbAddr,
  output wordT    wbData,
  output logic    retireValid,
  output regAddrT retireDest,
  output wordT    retireData,
  output logic    retireIllegal
);

  localparam int addrBits = $clog2(DMEM_WORDS);

  wordT                dmem [DMEM_WORDS];
  logic [addrBits-1:0] memAddr;
  wordT                memRdata;
  resultStateT         resState;

  // Word address of the byte address, wrapped to the memory depth
  assign memAddr  = exResult[addrBits+1:2];
  assign memRdata = dmem[memAddr];

  // Memory action of the current instruction
  always_comb begin
    if (exValid && exLoad) begin
      resState = resLoad;
    end else if (exValid && exStore) begin
      resState = resStore;
    end else begin
      resState = resIdle;
    end
  end

  // ----------------------------------------
  // Write-back to the register file
  // ----------------------------------------
  // Written on the same edge as the retire registers
  assign wbEnable = exValid && exWrite;
  assign wbAddr   = exDest;
  assign wbData   = (resState == resLoad) ? memRdata : exResult;

  // Data memory
  always_ff @(posedge begintest) begin
    if (!rstN) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (resState == resStore) begin
      dmem[memAddr] <= exStoreData;
    end
  end

  // ----------------------------------------
  // Retire port
  // ----------------------------------------
  always_ff @(posedge begintest) begin
    if (!rstN) begin
      retireValid   <= 1'b0;
      retireIllegal <= 1'b0;
    end else begin
      retireValid   <= exValid;
      retireIllegal <= exValid && exIllegal;
    end
  end

  // Dest is 0 whenever nothing was written
  // illegal retires zero data, sw retires its store data
  always_ff @(posedge begintest) begin
    retireDest <= wbEnable ? exDest : '0;
    if (resState == resStore) begin
      retireData <= exStoreData;
    end else if (exIllegal) begin
      retireData <= '0;
    end else begin
      retireData <= wbData;
    end
  end

endmodule

// ==== hdl/mipsCore.sv ====
// Top level of the core and an accepted instruction retires three clocks later in order
`timescale 1ns/1ps

module mipsCore
  import mipsPkg::*;
#(
  parameter int DMEM_WORDS = 64
) (
  input  logic    begintest,
  input  logic    rstN,
  input  logic    instValid,
  input  wordT    instWord,
  output logic    instReady,
  output logic    retireValid,
  output regAddrT retireDest,
  output wordT    retireData,
  output logic    retireIllegal
);

  // ----------------------------------------
  // Stage wires
  // ----------------------------------------
  // Register file read
  regAddrT rdAddrA;
  regAddrT rdAddrB;
  wordT    rdDataA;
  wordT    rdDataB;

  // Decode to execute
  logic    decValid;
  aluOpT   decAluOp;
  wordT    decOpA;
  wordT    decOpB;
  regAddrT decDest;
  logic    decWrite;
  logic    decLoad;
  logic    decStore;
  wordT    decStoreData;
  logic    decIllegal;

  // Execute to result
  logic    exValid;
  wordT    exResult;
  regAddrT exDest;
  logic    exWrite;
  logic    exLoad;
  logic    exStore;
  wordT    exStoreData;
  logic    exIllegal;

  // Write-back
  logic    wbEnable;
  regAddrT wbAddr;
  wordT    wbData;

  instDecode instDecode_inst (
    .begintest    (begintest),
    .rstN         (rstN),
    .instValid    (instValid),
    .instWord     (instWord),
    .instReady    (instReady),
    .rdAddrA      (rdAddrA),
    .rdAddrB      (rdAddrB),
    .rdDataA      (rdDataA),
    .rdDataB      (rdDataB),
    .exValid      (exValid),
    .exWrite      (exWrite),
    .exDest       (exDest),
    .wbEnable     (wbEnable),
    .wbAddr       (wbAddr),
    .decValid     (decValid),
    .decAluOp     (decAluOp),
    .decOpA       (decOpA),
    .decOpB       (decOpB),
    .decDest      (decDest),
    .decWrite     (decWrite),
    .decLoad      (decLoad),
    .decStore     (decStore),
    .decStoreData (decStoreData),
    .decIllegal   (decIllegal)
  );

  regFile regFile_inst (
    .begintest (begintest),
    .rstN      (rstN),
    .rdAddrA   (rdAddrA),
    .rdAddrB   (rdAddrB),
    .rdDataA   (rdDataA),
    .rdDataB   (rdDataB),
    .wbEnable  (wbEnable),
    .wbAddr    (wbAddr),
    .wbData    (wbData)
  );

  aluExecute aluExecute_inst (
    .begintest    (begintest),
    .rstN         (rstN),
    .decValid     (decValid),
    .decAluOp     (decAluOp),
    .decOpA       (decOpA),
    .decOpB       (decOpB),
    .decDest      (decDest),
    .decWrite     (decWrite),
    .decLoad      (decLoad),
    .decStore     (decStore),
    .decStoreData (decStoreData),
    .decIllegal   (decIllegal),
    .exValid      (exValid),
    .exResult     (exResult),
    .exDest       (exDest),
    .exWrite      (exWrite),
    .exLoad       (exLoad),
    .exStore      (exStore),
    .exStoreData  (exStoreData),
    .exIllegal    (exIllegal)
  );

  // Data memory depth passed down from here
  memResult #(
    .DMEM_WORDS (DMEM_WORDS)
  ) memResult_inst (
    .begintest     (begintest),
    .rstN          (rstN),
    .exValid       (exValid),
    .exResult      (exResult),
    .exDest        (exDest),
    .exWrite       (exWrite),
    .exLoad        (exLoad),
    .exStore       (exStore),
    .exStoreData   (exStoreData),
    .exIllegal     (exIllegal),
    .wbEnable      (wbEnable),
    .wbAddr        (wbAddr),
    .wbData        (wbData),
    .retireValid   (retireValid),
    .retireDest    (retireDest),
    .retireData    (retireData),
    .retireIllegal (retireIllegal)
  );

endmodule

// ==== hdl/mipsPkg.sv ====
// Shared types and MIPS encodings for the core and only the listed subset of opcodes is decoded
package mipsPkg;

  // ----------------------------------------
  // Widths that carry a meaning
  // ----------------------------------------
  typedef logic [31:0] wordT;
  typedef logic [4:0]  regAddrT;
  typedef logic [5:0]  opcodeT;
  typedef logic [5:0]  functT;
  typedef logic [15:0] immT;

  // ALU operations chosen by decode
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,
    aluLui
  } aluOpT;

  // Memory action of the result stage
  typedef enum logic [1:0] {
    resIdle,
    resLoad,
    resStore
  } resultStateT;

  // ----------------------------------------
  // Opcode field values
  // ----------------------------------------
  localparam opcodeT opRtype = 6'h00;
  localparam opcodeT opAddiu = 6'h09;
  localparam opcodeT opSlti  = 6'h0a;
  localparam opcodeT opAndi  = 6'h0c;
  localparam opcodeT opOri   = 6'h0d;
  localparam opcodeT opXori  = 6'h0e;
  localparam opcodeT opLui   = 6'h0f;
  localparam opcodeT opLw    = 6'h23;
  localparam opcodeT opSw    = 6'h2b;

  // Funct field values for R-type
  localparam functT fnAddu = 6'h21;
  localparam functT fnSubu = 6'h23;
  localparam functT fnAnd  = 6'h24;
  localparam functT fnOr   = 6'h25;
  localparam functT fnXor  = 6'h26;
  localparam functT fnSlt  = 6'h2a;

endpackage

// ==== hdl/regFile.sv ====
// Register file with combinational reads and no write-to-read bypass so a write shows up next cycle
`timescale 1ns/1ps

module regFile
  import mipsPkg::*;
(
  input  logic    begintest,
  input  logic    rstN,
  input  regAddrT rdAddrA,
  input  regAddrT rdAddrB,
  output wordT    rdDataA,
  output wordT    rdDataB,
  input  logic    wbEnable,
  input  regAddrT wbAddr,
  input  wordT    wbData
);

  // Register 0 has no storage
  wordT regs [1:31];

  // ----------------------------------------
  // Write port
  // ----------------------------------------
  always_ff @(posedge begintest) begin
    if (!rstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wbEnable && (wbAddr != '0)) begin
      regs[wbAddr] <= wbData;
    end
  end

  // ----------------------------------------
  // Read ports
  // ----------------------------------------
  // Register 0 always reads as zero
  always_comb begin
    if (rdAddrA == '0) begin
      rdDataA = '0;
    end else begin
      rdDataA = regs[rdAddrA];
    end
    if (rdAddrB == '0) begin
      rdDataB = '0;
    end else begin
      rdDataB = regs[rdAddrB];
    end
  end

endmodule

// ==== mipsCore.f ====
hdl/mipsPkg.sv
hdl/regFile.sv
hdl/instDecode.sv
hdl/aluExecute.sv
hdl/memResult.sv
hdl/mipsCore.sv
sim/mipsCore_sva.sv
sim/mipsCoreTb.sv

// ==== sim/mipsCoreTb.sv ====
// Table-driven testbench for the core; memory wrap rows assume DMEM_WORDS of 64
`timescale 1ns/1ps

module mipsCoreTb
  import mipsPkg::*;
();

  localparam int clkPeriodNs = 4;
  localparam int resetCycles = 4;
  localparam int dmemWords   = 64;

  logic    begintest;
  logic    rstN;
  logic    instValid;
  wordT    instWord;
  logic    instReady;
  logic    retireValid;
  regAddrT retireDest;
  wordT    retireData;
  logic    retireIllegal;

  // Stimulus table columns with one entry per row
  wordT    instTab[$];
  regAddrT destTab[$];
  wordT    dataTab[$];
  logic    illTab[$];
  // Row goes straight after the previous one with no idle gap
  logic    chainTab[$];

  int          rowCount;
  int          retiredCount;
  int          stallCount;
  logic        tableReady;

  mipsCore #(
    .DMEM_WORDS (dmemWords)
  ) mipsCore_inst (
    .begintest     (begintest),
    .rstN          (rstN),
    .instValid     (instValid),
    .instWord      (instWord),
    .instReady     (instReady),
    .retireValid   (retireValid),
    .retireDest    (retireDest),
    .retireData    (retireData),
    .retireIllegal (retireIllegal)
  );

  initial begin
    begintest = 1'b0;
    forever #(clkPeriodNs / 2) begintest = ~begintest;
  end

  // ----------------------------------------
  // Instruction encoding
  // ----------------------------------------
  function automatic wordT encodeR(functT fn, int rd, int rs, int rt);
    return {opRtype, regAddrT'(rs), regAddrT'(rt), regAddrT'(rd), 5'd0, fn};
  endfunction

  function automatic wordT encodeI(opcodeT op, int rt, int rs, immT imm);
    return {op, regAddrT'(rs), regAddrT'(rt), imm};
  endfunction

  task automatic addRow(wordT word, int dest, wordT data, logic illegal, logic chained);
    instTab.push_back(word);
    destTab.push_back(regAddrT'(dest));
    dataTab.push_back(data);
    illTab.push_back(illegal);
    chainTab.push_back(chained);
  endtask

  // Expected values worked out by hand from the ALU and extension rules
  task automatic buildTable();
    // Every source register and an untouched memory word read as zero before any write
    addRow(encodeR(fnOr, 20, 1, 2), 20, 32'h00000000, 1'b0, 1'b0);
    addRow(encodeR(fnOr, 21, 3, 4), 21, 32'h00000000, 1'b0, 1'b0);
    addRow(encodeR(fnOr, 22, 5, 6), 22, 32'h00000000, 1'b0, 1'b0);
    addRow(encodeR(fnOr, 30, 7, 13), 30, 32'h00000000, 1'b0, 1'b0);
    addRow(encodeR(fnOr, 31, 23, 24), 31, 32'h00000000, 1'b0, 1'b0);
    addRow(encodeR(fnOr, 19, 25, 0), 19, 32'h00000000, 1'b0, 1'b0);
    addRow(encodeI(opLw, 27, 0, 16'h0030), 27, 32'h00000000, 1'b0, 1'b0);
    // Immediate extension
    addRow(encodeI(opAddiu, 1, 0, 16'hffff), 1, 32'hffffffff, 1'b0, 1'b0);
    addRow(encodeI(opAddiu, 2, 0, 16'h7fff), 2, 32'h00007fff, 1'b0, 1'b0);
    addRow(encodeI(opAddiu, 3, 0, 16'h8000), 3, 32'hffff8000, 1'b0, 1'b0);
    addRow(encodeI(opAddiu, 4, 0, 16'h4000), 4, 32'h00004000, 1'b0, 1'b0);
    addRow(encodeI(opOri,   5, 0, 16'h8000), 5, 32'h00008000, 1'b0, 1'b0);
    addRow(encodeI(opAndi,  6, 1, 16'h8000), 6, 32'h00008000, 1'b0, 1'b0);
    addRow(encodeI(opLui,   7, 0, 16'h1234), 7, 32'h12340000, 1'b0, 1'b0);
    // R-type ALU with subu wrapping
    addRow(encodeR(fnAddu,  8, 2, 4),  8, 32'h0000bfff, 1'b0, 1'b0);
    addRow(encodeR(fnSubu,  9, 0, 1),  9, 32'h00000001, 1'b0, 1'b0);
    addRow(encodeR(fnSubu, 10, 4, 2), 10, 32'hffffc001, 1'b0, 1'b0);
    addRow(encodeR(fnAnd,  11, 1, 7), 11, 32'h12340000, 1'b0, 1'b0);
    addRow(encodeR(fnOr,   12, 3, 2), 12, 32'hffffffff, 1'b0, 1'b0);
    addRow(encodeR(fnXor,  13, 7, 1), 13, 32'hedcbffff, 1'b0, 1'b0);
    // Signed compares with r3 negative
    addRow(encodeR(fnSlt,  14, 3, 2), 14, 32'h00000001, 1'b0, 1'b0);
    addRow(encodeR(fnSlt,  15, 2, 3), 15, 32'h00000000, 1'b0, 1'b0);
    addRow(encodeI(opSlti, 16, 3, 16'h0001), 16, 32'h00000001, 1'b0, 1'b0);
    addRow(encodeI(opSlti, 17, 2, 16'hffff), 17, 32'h00000000, 1'b0, 1'b0);
    addRow(encodeI(opXori, 18, 2, 16'hffff), 18, 32'h00008000, 1'b0, 1'b0);
    // Dependent chain sent back to back so the interlock must stall
    addRow(encodeI(opAddiu, 23, 0, 16'h0005), 23, 32'h00000005, 1'b0, 1'b0);
    addRow(encodeR(fnAddu, 24, 23, 23), 24, 32'h0000000a, 1'b0, 1'b1);
    addRow(encodeR(fnSubu, 25, 24, 23), 25, 32'h00000005, 1'b0, 1'b1);
    addRow(encodeI(opAddiu, 26, 25, 16'h0003), 26, 32'h00000008, 1'b0, 1'b1);
    // Memory rows where byte 0x110 and 0x120 wrap onto words 4 and 8
    addRow(encodeI(opSw, 7, 0, 16'h0010), 0, 32'h12340000, 1'b0, 1'b0);
    addRow(encodeI(opLw, 27, 0, 16'h0010), 27, 32'h12340000, 1'b0, 1'b0);
    addRow(encodeI(opLw, 28, 0, 16'h0110), 28, 32'h12340000, 1'b0, 1'b0);
    addRow(encodeI(opSw, 13, 0, 16'h0020), 0, 32'hedcbffff, 1'b0, 1'b0);
    addRow(encodeI(opLw, 29, 0, 16'h0120), 29, 32'hedcbffff, 1'b0, 1'b0);
    // Register 0 ignores the write but the sum still retires
    addRow(encodeI(opAddiu, 0, 0, 16'h1234), 0, 32'h00001234, 1'b0, 1'b0);
    addRow(encodeR(fnAddu, 30, 0, 0), 30, 32'h00000000, 1'b0, 1'b0);
    // Unknown opcode and unknown funct before r5 and r6 read back unchanged
    addRow(encodeI(6'h3f, 5, 0, 16'h0077), 0, 32'h00000000, 1'b1, 1'b0);
    addRow(encodeR(6'h3f, 6, 1, 1), 0, 32'h00000000, 1'b1, 1'b0);
    addRow(encodeR(fnOr, 31, 5, 0), 31, 32'h00008000, 1'b0, 1'b0);
    addRow(encodeR(fnOr, 19, 6, 0), 19, 32'h00008000, 1'b0, 1'b0);
  endtask

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic checkWord(string name, wordT got, wordT expected);
    if (got !== expected) begin
      $display("CHECK FAILED: %s got %h expected %h", name, got, expected);
      $display("TEST FAILED");
      $fatal(1, "word mismatch on %s", name);
    end
  endtask

  task automatic checkReg(string name, regAddrT got, regAddrT expected);
    if (got !== expected) begin
      $display("CHECK FAILED: %s got %h expected %h", name, got, expected);
      $display("TEST FAILED");
      $fatal(1, "register mismatch on %s", name);
    end
  endtask

  task automatic checkFlag(string name, logic got, logic expected);
    if (got !== expected) begin
      $display("CHECK FAILED: %s got %h expected %h", name, got, expected);
      $display("TEST FAILED");
      $fatal(1, "flag mismatch on %s", name);
    end
  endtask

  // Called just after an edge; instReady sampled mid-cycle decides the accept
  task automatic sendInst(wordT word);
    logic ready;
    instValid = 1'b1;
    instWord  = word;
    do begin
      #2;
      ready = instReady;
      @(posedge begintest);
      #1;
      if (!ready) begin
        stallCount++;
      end
    end while (!ready);
    instValid = 1'b0;
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin : stimulus
    int unsigned gap;
    rstN         = 1'b0;
    instValid    = 1'b0;
    instWord     = '0;
    tableReady   = 1'b0;
    retiredCount = 0;
    stallCount   = 0;
    void'($urandom(44));
    buildTable();
    rowCount   = instTab.size();
    tableReady = 1'b1;
    repeat (resetCycles) @(posedge begintest);
    #1;
    rstN = 1'b1;
    // Idle core straight out of reset
    checkFlag("instReady", instReady, 1'b1);
    checkFlag("retireValid", retireValid, 1'b0);
    for (int i = 0; i < rowCount; i++) begin
      if (!chainTab[i]) begin
        gap = $urandom % 3;
        repeat (gap) begin
          @(posedge begintest);
          #1;
        end
      end
      sendInst(instTab[i]);
    end
    wait (retiredCount == rowCount);
    // Catch any stray retire after the last row
    repeat (4) @(posedge begintest);
    checkFlag("interlock stall seen", stallCount != 0, 1'b1);
    $display("TEST PASSED");
    $finish;
  end

  // ----------------------------------------
  // Retire monitor
  // ----------------------------------------
  // Mid-cycle sampling keeps clear of the edge updates
  initial begin : retireMonitor
    wait (tableReady);
    forever begin
      @(negedge begintest);
      if (rstN && retireValid) begin
        if (retiredCount >= rowCount) begin
          $display("Core retired an instruction that was never sent");
          $display("TEST FAILED");
          $fatal(1, "unexpected retire");
        end else begin
          checkReg($sformatf("retireDest row %0d", retiredCount),
                   retireDest, destTab[retiredCount]);
          checkWord($sformatf("retireData row %0d", retiredCount),
                    retireData, dataTab[retiredCount]);
          checkFlag($sformatf("retireIllegal row %0d", retiredCount),
                    retireIllegal, illTab[retiredCount]);
          retiredCount++;
        end
      end
    end
  end

  // Per row at most 2 gap, 3 stall, 3 latency and 1 accept cycle
  initial begin : watchdog
    int limitNs;
    wait (tableReady);
    limitNs = rowCount * (2 + 3 + 3 + 1) * clkPeriodNs + resetCycles * clkPeriodNs;
    #(limitNs);
    $display("Watchdog expired after %0d ns with %0d of %0d rows retired",
             limitNs, retiredCount, rowCount);
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

endmodule

// ==== sim/mipsCore_sva.sv ====
// Bound checks on the instruction handshake and retire port, valid only for the fixed 3-cycle latency
`timescale 1ns/1ps

module mipsCoreSva
  import mipsPkg::*;
(
  input logic    begintest,
  input logic    rstN,
  input logic    instValid,
  input wordT    instWord,
  input logic    instReady,
  input logic    retireValid,
  input regAddrT retireDest,
  input logic    retireIllegal
);

  // ----------------------------------------
  // Handshake
  // ----------------------------------------
  // A stalled instruction word must be held by the source
  assert property (@(posedge begintest) disable iff (!rstN)
    ($past(instValid) && !$past(instReady)) |-> $stable(instWord))
    else $error("instWord changed while the core was stalling it");

  // ----------------------------------------
  // Retire port
  // ----------------------------------------
  // First cycle out of reset has nothing to retire
  assert property (@(posedge begintest) (rstN && $past(!rstN)) |-> !retireValid)
    else $error("retireValid high in the cycle after reset");

  // Every accept shows up exactly three edges later
  assert property (@(posedge begintest) disable iff (!rstN)
    retireValid == $past(instValid && instReady, 3))
    else $error("retireValid does not follow an accept by 3 cycles");

  // Illegal instructions name no destination
  assert property (@(posedge begintest) disable iff (!rstN)
    retireIllegal |-> (retireDest == '0))
    else $error("retireDest nonzero on an illegal retire");

endmodule

bind mipsCore mipsCoreSva mipsCoreSva_inst (
  .begintest     (begintest),
  .rstN          (rstN),
  .instValid     (instValid),
  .instWord      (instWord),
  .instReady     (instReady),
  .retireValid   (retireValid),
  .retireDest    (retireDest),
  .retireIllegal (retireIllegal)
);
